/* run_sim.sh */
#!/bin/sh
# build and run the hazard control testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module pipe_ctrl_tb -Mdir obj_dir -f verilog.f; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vpipe_ctrl_tb)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^TEST PASSED$"; then
	exit 0
fi
exit 1

/* verif/pipe_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_tb import defines::*; ();

	localparam int RESET_CYCLES  = 10;
	localparam int RESET_TIMEOUT = 50;
	localparam int SAMPLE_DELAY  = 5;

	// status inputs as one bundle
	typedef struct packed {
		logic sdram_init_done;
		logic execute_busy;
		logic mem_access_done;
		logic branch_taken_d;
		logic branch_taken_x;
	} status_t;

	localparam status_t RUN      = 5'b10100;
	localparam status_t TAKEN_D  = 5'b10110;
	localparam status_t TAKEN_X  = 5'b10101;
	localparam status_t MEM_WAIT = 5'b10000;
	localparam status_t BUSY     = 5'b11100;
	localparam status_t NO_SDRAM = 5'b01100;

	// one cycle of stimulus and the outputs expected before the next rising edge
	typedef struct packed {
		logic [31:0] word;
		logic        valid;
		status_t     status;
		fwd_t        fwd;
		stage_ctl_t  stall;
		stage_ctl_t  flush;
	} row_t;

	logic        clk;
	logic        arst_n;
	logic [31:0] instr_word;
	logic        instr_valid;
	status_t     status;
	fwd_t        fwd;
	stage_ctl_t  stall;
	stage_ctl_t  flush;

	row_t   rows[$];
	integer seed;
	int     errors;

	pipe_ctrl_top DUT (
		.clk             (clk),
		.arst_n          (arst_n),
		.instr_word      (instr_word),
		.instr_valid     (instr_valid),
		.sdram_init_done (status.sdram_init_done),
		.execute_busy    (status.execute_busy),
		.mem_access_done (status.mem_access_done),
		.branch_taken_d  (status.branch_taken_d),
		.branch_taken_x  (status.branch_taken_x),
		.fwd             (fwd),
		.stall           (stall),
		.flush           (flush)
	);

	initial begin : clock_gen
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	initial begin : reset_gen
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic logic [31:0] enc_r(input r_t rd, input r_t rs1, input r_t rs2);
		return {7'b0000000, rs2, rs1, 3'b000, rd, R};
	endfunction

	// random immediate also covers the unused rs2 slot
	function automatic logic [31:0] enc_i(input opcode_t op, input r_t rd, input r_t rs1);
		logic [31:0] fill;
		fill = rand_word();
		return {fill[11:0], rs1, 3'b000, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input r_t rs1, input r_t rs2);
		return {7'b0000000, rs2, rs1, 3'b010, 5'b00000, STORE};
	endfunction

	function automatic logic [31:0] enc_b(input r_t rs1, input r_t rs2);
		return {7'b0000000, rs2, rs1, 3'b000, 5'b00000, B};
	endfunction

	// jump offset bits land on both rs slots
	function automatic logic [31:0] enc_j(input r_t rd);
		logic [31:0] fill;
		fill = rand_word();
		return {fill[19:0], rd, JAL};
	endfunction

	task automatic add_row(
		input logic [31:0] word,
		input logic        valid,
		input status_t     st,
		input fwd_t        exp_fwd,
		input stage_ctl_t  exp_stall,
		input stage_ctl_t  exp_flush
	);
		row_t row;
		row.word   = word;
		row.valid  = valid;
		row.status = st;
		row.fwd    = exp_fwd;
		row.stall  = exp_stall;
		row.flush  = exp_flush;
		rows.push_back(row);
	endtask

	// fwd bits are id_rs1 id_rs2 ex_rs1 ex_rs2 mem_rs1 mem_rs2
	// stall and flush bits are pc if_id id_ex ex_mem mem_wb
	task automatic build_table();
		logic [31:0] held;
		// alu chain through x1 to x4 with a write to x0
		add_row(enc_i(I, 5'd1, 5'd0), 1'b1, RUN, 10'b00_00_00_00_0_0, 5'b00000, 5'b00000);
		add_row(enc_r(5'd2, 5'd1, 5'd1), 1'b1, RUN, 10'b00_00_00_00_0_0, 5'b00000, 5'b00000);
		add_row(enc_r(5'd3, 5'd2, 5'd1), 1'b1, RUN, 10'b00_00_00_00_0_0, 5'b00000, 5'b00000);
		add_row(enc_r(5'd0, 5'd3, 5'd2), 1'b1, RUN, 10'b00_00_01_01_0_0, 5'b00000, 5'b00000);
		add_row(enc_r(5'd4, 5'd0, 5'd3), 1'b1, RUN, 10'b00_00_01_10_0_0, 5'b00000, 5'b00000);
		add_row(enc_s(5'd3, 5'd4), 1'b1, RUN, 10'b00_00_01_10_0_0, 5'b00000, 5'b00000);
		add_row(enc_b(5'd4, 5'd3), 1'b1, RUN, 10'b00_01_00_10_0_0, 5'b00000, 5'b00000);
		add_row(enc_b(5'd4, 5'd0), 1'b1, RUN, 10'b10_00_00_00_0_0, 5'b00000, 5'b00000);
		add_row(rand_word(), 1'b0, RUN, 10'b11_00_00_00_0_1, 5'b00000, 5'b00000);
		// load feeding a taken branch
		add_row(enc_i(LOAD, 5'd7, 5'd0), 1'b1, RUN, 10'b00_00_00_00_0_0, 5'b00000, 5'b00000);
		add_row(enc_b(5'd7, 5'd1), 1'b1, RUN, 10'b00_00_00_00_0_0, 5'b00000, 5'b00000);
		held = enc_i(I, 5'd8, 5'd0);
		add_row(held, 1'b1, TAKEN_D, 10'b01_00_00_00_0_0, 5'b11000, 5'b00000);
		add_row(held, 1'b1, TAKEN_D, 10'b10_00_00_00_0_0, 5'b11000, 5'b00000);
		add_row(held, 1'b1, TAKEN_D, 10'b11_00_00_00_0_0, 5'b00000, 5'b10000);
		add_row(enc_i(I, 5'd9, 5'd0), 1'b1, TAKEN_X, 10'b00_00_00_00_0_0, 5'b00000, 5'b01000);
		// load waits in m for the memory
		add_row(enc_i(LOAD, 5'd11, 5'd0), 1'b1, RUN, 10'b00_00_00_00_0_0, 5'b00000, 5'b00000);
		add_row(enc_r(5'd12, 5'd11, 5'd0), 1'b1, RUN, 10'b00_00_00_00_0_0, 5'b00000, 5'b00000);
		add_row(enc_i(I, 5'd13, 5'd12), 1'b1, RUN, 10'b00_00_00_00_0_0, 5'b00000, 5'b00000);
		held = enc_i(I, 5'd14, 5'd13);
		add_row(held, 1'b1, MEM_WAIT, 10'b00_00_01_00_0_0, 5'b11111, 5'b00000);
		add_row(held, 1'b1, MEM_WAIT, 10'b00_00_01_00_0_0, 5'b11111, 5'b00000);
		add_row(held, 1'b1, RUN, 10'b00_00_01_00_0_0, 5'b00000, 5'b00000);
		add_row(rand_word(), 1'b0, RUN, 10'b00_00_01_00_0_0, 5'b00000, 5'b00000);
		// jal redirects from d and again from x
		add_row(enc_j(5'd1), 1'b1, RUN, 10'b00_00_01_00_0_0, 5'b00000, 5'b00000);
		add_row(enc_i(I, 5'd15, 5'd0), 1'b1, RUN, 10'b00_00_00_00_0_0, 5'b00000, 5'b10000);
		add_row(rand_word(), 1'b0, RUN, 10'b00_00_00_00_0_0, 5'b00000, 5'b01000);
		// back-pressure from execute and sdram
		add_row(rand_word(), 1'b0, BUSY, 10'b00_00_00_00_0_0, 5'b11100, 5'b00000);
		add_row(rand_word(), 1'b0, NO_SDRAM, 10'b00_00_00_00_0_0, 5'b11111, 5'b00000);
		add_row(rand_word(), 1'b0, BUSY, 10'b00_00_00_00_0_0, 5'b11100, 5'b00000);
		// sys drains and freezes the pipe
		add_row({25'd0, SYS}, 1'b1, RUN, 10'b00_00_00_00_0_0, 5'b00000, 5'b00000);
		held = enc_i(I, 5'd20, 5'd0);
		add_row(held, 1'b1, RUN, 10'b00_00_00_00_0_0, 5'b10000, 5'b00000);
		add_row(held, 1'b1, RUN, 10'b00_00_00_00_0_0, 5'b11000, 5'b00000);
		add_row(held, 1'b1, RUN, 10'b00_00_00_00_0_0, 5'b11100, 5'b00000);
		add_row(held, 1'b1, RUN, 10'b00_00_00_00_0_0, 5'b11111, 5'b00000);
		add_row(held, 1'b1, RUN, 10'b00_00_00_00_0_0, 5'b11111, 5'b00000);
	endtask

	task automatic stop_on_error();
		errors++;
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic wait_reset_release();
		int count;
		count = 0;
		while (arst_n !== 1'b1) begin
			@(posedge clk);
			count++;
			if (count > RESET_TIMEOUT) begin
				$display("reset was not released within %0d clock cycles", RESET_TIMEOUT);
				stop_on_error();
			end
		end
	endtask

	task automatic check_row(input int idx, input row_t row);
		assert (fwd == row.fwd) else begin
			$display("FAIL t=%0t row %0d fwd is %b expected %b", $time, idx, fwd, row.fwd);
			stop_on_error();
		end
		assert (stall == row.stall) else begin
			$display("FAIL t=%0t row %0d stall is %b expected %b", $time, idx, stall, row.stall);
			stop_on_error();
		end
		assert (flush == row.flush) else begin
			$display("FAIL t=%0t row %0d flush is %b expected %b", $time, idx, flush, row.flush);
			stop_on_error();
		end
	endtask

	initial begin : stimulus
		seed        = 10443;
		errors      = 0;
		instr_word  = 32'h0;
		instr_valid = 1'b0;
		status      = RUN;
		build_table();
		wait_reset_release();
		for (int n = 0; n < rows.size(); n++) begin
			@(negedge clk);
			instr_word  = rows[n].word;
			instr_valid = rows[n].valid;
			status      = rows[n].status;
			#SAMPLE_DELAY;
			check_row(n, rows[n]);
		end
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule : pipe_ctrl_tb

`default_nettype wire

/* verilog.f */
verilog/defines.sv
verilog/instr_decoder.sv
verilog/stage_tracker.sv
verilog/hazard_ctrl.sv
verilog/pipe_ctrl_top.sv
verif/pipe_ctrl_tb.sv

/* verilog/defines.sv */
`default_nettype none

package defines;

	// rv32i major opcodes, nop doubles as bubble and unknown opcode
	typedef enum logic [6:0] {
		NOP   = 7'b0000000,
		LOAD  = 7'b0000011,
		FENCE = 7'b0001111,
		I     = 7'b0010011,
		AUIPC = 7'b0010111,
		STORE = 7'b0100011,
		R     = 7'b0110011,
		LUI   = 7'b0110111,
		B     = 7'b1100011,
		JALR  = 7'b1100111,
		JAL   = 7'b1101111,
		SYS   = 7'b1110011
	} opcode_t;

	typedef logic [4:0] r_t;

	localparam r_t X0 = 5'd0;

	// compact record carried down the pipe
	typedef struct packed {
		opcode_t opcode;
		r_t      rd;
		r_t      rs1;
		r_t      rs2;
		logic    rd_write;
	} instr_t;

	localparam instr_t NOP_INSTR = '{
		opcode:   NOP,
		rd:       X0,
		rs1:      X0,
		rs2:      X0,
		rd_write: 1'b0
	};

	// operand source selects per consuming stage
	typedef enum logic [1:0] {
		RS_ID_SEL,
		EX_ID_SEL,
		MEM_ID_SEL,
		WB_ID_SEL
	} id_fwd_sel_t;

	typedef enum logic [1:0] {
		RS_EX_SEL,
		MEM_EX_SEL,
		WB_EX_SEL
	} ex_fwd_sel_t;

	typedef enum logic {
		RS_MEM_SEL,
		WB_MEM_SEL
	} mem_fwd_sel_t;

	typedef struct packed {
		id_fwd_sel_t  id_rs1;
		id_fwd_sel_t  id_rs2;
		ex_fwd_sel_t  ex_rs1;
		ex_fwd_sel_t  ex_rs2;
		mem_fwd_sel_t mem_rs1;
		mem_fwd_sel_t mem_rs2;
	} fwd_t;

	// one bit per pipeline register, shared by stall and flush
	typedef struct packed {
		logic pc;
		logic if_id;
		logic id_ex;
		logic ex_mem;
		logic mem_wb;
	} stage_ctl_t;

	localparam logic ENABLE  = 1'b1;
	localparam logic DISABLE = 1'b0;

endpackage : defines

`default_nettype wire

/* verilog/hazard_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl import defines::*; (
	// records from every stage
	input  instr_t     instr_f,
	input  instr_t     instr_d,
	input  instr_t     instr_x,
	input  instr_t     instr_m,
	input  instr_t     instr_w,

	input  logic       instr_valid_d,

	input  logic       ex_rd_write,
	input  logic       mem_rd_write,
	input  logic       wb_rd_write,

	// status from the outside world
	input  logic       sdram_init_done,
	input  logic       execute_busy,
	input  logic       mem_access_done,
	input  logic       branch_taken_d,
	input  logic       branch_taken_x,

	output fwd_t       fwd,
	output stage_ctl_t stall,
	output stage_ctl_t flush
);

	// consumer reads rs, producer writes rd, same non-zero register
	function automatic logic depends(
		input logic rs_read,
		input r_t   rs,
		input logic rd_write,
		input r_t   rd
	);
		return rs_read && (rs != X0) && rd_write && (rd == rs);
	endfunction

	logic id_rs1_read, id_rs2_read;
	logic ex_rs1_read, ex_rs2_read;
	logic mem_rs1_read, mem_rs2_read;

	// branches and jalr resolve in d, stores need rs2 early
	always_comb begin : rs_read_map
		id_rs1_read  = (instr_d.opcode == B) || (instr_d.opcode == JALR);
		id_rs2_read  = (instr_d.opcode == B) || (instr_d.opcode == STORE);

		ex_rs1_read  = (instr_x.opcode == R) ||
		               (instr_x.opcode == I) ||
		               (instr_x.opcode == LOAD) ||
		               (instr_x.opcode == STORE) ||
		               (instr_x.opcode == JALR);
		ex_rs2_read  = (instr_x.opcode == R);

		mem_rs1_read = (instr_m.opcode == LOAD) || (instr_m.opcode == STORE);
		mem_rs2_read = (instr_m.opcode == STORE);
	end

	logic ex2id_1, ex2id_2;
	logic mem2id_1, mem2id_2;
	logic wb2id_1, wb2id_2;
	logic mem2ex_1, mem2ex_2;
	logic wb2ex_1, wb2ex_2;
	logic wb2mem_1, wb2mem_2;

	always_comb begin : dep_detect
		ex2id_1  = depends(id_rs1_read, instr_d.rs1, ex_rd_write, instr_x.rd);
		ex2id_2  = depends(id_rs2_read, instr_d.rs2, ex_rd_write, instr_x.rd);
		mem2id_1 = depends(id_rs1_read, instr_d.rs1, mem_rd_write, instr_m.rd);
		mem2id_2 = depends(id_rs2_read, instr_d.rs2, mem_rd_write, instr_m.rd);
		wb2id_1  = depends(id_rs1_read, instr_d.rs1, wb_rd_write, instr_w.rd);
		wb2id_2  = depends(id_rs2_read, instr_d.rs2, wb_rd_write, instr_w.rd);

		mem2ex_1 = depends(ex_rs1_read, instr_x.rs1, mem_rd_write, instr_m.rd);
		mem2ex_2 = depends(ex_rs2_read, instr_x.rs2, mem_rd_write, instr_m.rd);
		wb2ex_1  = depends(ex_rs1_read, instr_x.rs1, wb_rd_write, instr_w.rd);
		wb2ex_2  = depends(ex_rs2_read, instr_x.rs2, wb_rd_write, instr_w.rd);

		wb2mem_1 = depends(mem_rs1_read, instr_m.rs1, wb_rd_write, instr_w.rd);
		wb2mem_2 = depends(mem_rs2_read, instr_m.rs2, wb_rd_write, instr_w.rd);
	end

	// youngest producer first
	always_comb begin : fwd_select
		fwd.id_rs1  = ex2id_1  ? EX_ID_SEL  :
		              mem2id_1 ? MEM_ID_SEL :
		              wb2id_1  ? WB_ID_SEL  : RS_ID_SEL;
		fwd.id_rs2  = ex2id_2  ? EX_ID_SEL  :
		              mem2id_2 ? MEM_ID_SEL :
		              wb2id_2  ? WB_ID_SEL  : RS_ID_SEL;

		fwd.ex_rs1  = mem2ex_1 ? MEM_EX_SEL :
		              wb2ex_1  ? WB_EX_SEL  : RS_EX_SEL;
		fwd.ex_rs2  = mem2ex_2 ? MEM_EX_SEL :
		              wb2ex_2  ? WB_EX_SEL  : RS_EX_SEL;

		fwd.mem_rs1 = wb2mem_1 ? WB_MEM_SEL : RS_MEM_SEL;
		fwd.mem_rs2 = wb2mem_2 ? WB_MEM_SEL : RS_MEM_SEL;
	end

	logic data_mem_stall;
	logic load_x, load_m;
	logic dec_rs1_use, dec_rs2_use;
	logic load_hazard_x, load_hazard_m;
	logic load_stall;

	always_comb begin : load_use_detect
		data_mem_stall = ((instr_m.opcode == LOAD) || (instr_m.opcode == STORE)) &&
		                 !mem_access_done;

		load_x = (instr_x.opcode == LOAD);
		load_m = (instr_m.opcode == LOAD);

		// load data is not ready in time for a compare or target in d
		dec_rs1_use = (instr_d.opcode == B) || (instr_d.opcode == JALR);
		dec_rs2_use = (instr_d.opcode == B);

		load_hazard_x = depends(dec_rs1_use, instr_d.rs1, load_x, instr_x.rd) ||
		                depends(dec_rs2_use, instr_d.rs2, load_x, instr_x.rd);
		load_hazard_m = depends(dec_rs1_use, instr_d.rs1, load_m, instr_m.rd) ||
		                depends(dec_rs2_use, instr_d.rs2, load_m, instr_m.rd);

		load_stall = (load_hazard_x || load_hazard_m) && !data_mem_stall;
	end

	logic sys_d, sys_x, sys_m, sys_w;

	// a sys anywhere downstream freezes the stage behind it
	always_comb begin : sys_drain
		sys_w = (instr_w.opcode == SYS);
		sys_m = (instr_m.opcode == SYS) || sys_w;
		sys_x = (instr_x.opcode == SYS) || sys_m;
		sys_d = (instr_d.opcode == SYS) || sys_x;
	end

	logic mem_hold;

	always_comb begin : stall_gen
		mem_hold     = data_mem_stall || !sdram_init_done;

		stall.pc     = mem_hold || load_stall || execute_busy || sys_d;
		stall.if_id  = mem_hold || load_stall || execute_busy || sys_x;
		stall.id_ex  = mem_hold || execute_busy || sys_m;
		stall.ex_mem = mem_hold || sys_w;
		// w also holds so mem can keep forwarding from it
		stall.mem_wb = mem_hold || sys_w;
	end

	logic jump_d, jump_x;
	logic taken_d, taken_x;
	logic redirect_d;

	always_comb begin : flush_gen
		jump_d  = (instr_d.opcode == JAL) || (instr_d.opcode == JALR);
		jump_x  = (instr_x.opcode == JAL) || (instr_x.opcode == JALR);
		taken_d = (instr_d.opcode == B) && branch_taken_d;
		taken_x = (instr_x.opcode == B) && branch_taken_x;

		redirect_d = (jump_d || taken_d) && instr_valid_d;

		// a branch still waiting on load data has not resolved yet
		if (load_hazard_x || load_hazard_m) begin
			flush.pc = DISABLE;
		end else begin
			flush.pc = redirect_d;
		end

		flush.if_id  = jump_x || taken_x;
		flush.id_ex  = DISABLE;
		flush.ex_mem = DISABLE;
		flush.mem_wb = DISABLE;
	end

endmodule : hazard_ctrl

`default_nettype wire

/* verilog/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import defines::*; (
	input  logic [31:0] instr_word,
	input  logic        instr_valid,
	output instr_t      instr
);

	opcode_t op;
	logic use_rd;
	logic use_rs1;
	logic use_rs2;
	logic writes_rd;

	// anything outside the rv32i major opcodes decodes as a bubble
	always_comb begin : opcode_map
		case (instr_word[6:0])
			R, I, LOAD, STORE, B, JAL, JALR, LUI, AUIPC, SYS, FENCE: begin
				op = opcode_t'(instr_word[6:0]);
			end
			default: begin
				op = NOP;
			end
		endcase
	end

	// register fields used by each format
	always_comb begin : field_use
		use_rd    = 1'b0;
		use_rs1   = 1'b0;
		use_rs2   = 1'b0;
		writes_rd = 1'b0;
		case (op)
			R: begin
				use_rd    = 1'b1;
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				writes_rd = 1'b1;
			end
			I, LOAD, JALR: begin
				use_rd    = 1'b1;
				use_rs1   = 1'b1;
				writes_rd = 1'b1;
			end
			// i-type layout, no tracked write back
			SYS, FENCE: begin
				use_rd  = 1'b1;
				use_rs1 = 1'b1;
			end
			STORE, B: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			JAL, LUI, AUIPC: begin
				use_rd    = 1'b1;
				writes_rd = 1'b1;
			end
			default: begin
				use_rd = 1'b0;
			end
		endcase
	end

	always_comb begin : record_build
		instr = NOP_INSTR;
		if (instr_valid) begin
			instr.opcode   = op;
			instr.rd       = use_rd  ? instr_word[11:7]  : X0;
			instr.rs1      = use_rs1 ? instr_word[19:15] : X0;
			instr.rs2      = use_rs2 ? instr_word[24:20] : X0;
			// writes to x0 are dropped here so no stage ever forwards them
			instr.rd_write = writes_rd && (instr_word[11:7] != X0);
		end
	end

endmodule : instr_decoder

`default_nettype wire

/* verilog/pipe_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_top import defines::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [31:0] instr_word,
	input  logic        instr_valid,
	input  logic        sdram_init_done,
	input  logic        execute_busy,
	input  logic        mem_access_done,
	input  logic        branch_taken_d,
	input  logic        branch_taken_x,
	output fwd_t        fwd,
	output stage_ctl_t  stall,
	output stage_ctl_t  flush
);

	instr_t instr_f;
	instr_t instr_d, instr_x, instr_m, instr_w;
	logic   instr_valid_d;
	logic   ex_rd_write, mem_rd_write, wb_rd_write;

	instr_decoder u_decoder (
		.instr_word  (instr_word),
		.instr_valid (instr_valid),
		.instr       (instr_f)
	);

	// stall and flush loop back from the hazard controller
	stage_tracker u_tracker (
		.clk           (clk),
		.arst_n        (arst_n),
		.instr_f       (instr_f),
		.stall         (stall),
		.flush         (flush),
		.instr_d       (instr_d),
		.instr_x       (instr_x),
		.instr_m       (instr_m),
		.instr_w       (instr_w),
		.instr_valid_d (instr_valid_d),
		.ex_rd_write   (ex_rd_write),
		.mem_rd_write  (mem_rd_write),
		.wb_rd_write   (wb_rd_write)
	);

	hazard_ctrl u_hazard (
		.instr_f         (instr_f),
		.instr_d         (instr_d),
		.instr_x         (instr_x),
		.instr_m         (instr_m),
		.instr_w         (instr_w),
		.instr_valid_d   (instr_valid_d),
		.ex_rd_write     (ex_rd_write),
		.mem_rd_write    (mem_rd_write),
		.wb_rd_write     (wb_rd_write),
		.sdram_init_done (sdram_init_done),
		.execute_busy    (execute_busy),
		.mem_access_done (mem_access_done),
		.branch_taken_d  (branch_taken_d),
		.branch_taken_x  (branch_taken_x),
		.fwd             (fwd),
		.stall           (stall),
		.flush           (flush)
	);

endmodule : pipe_ctrl_top

`default_nettype wire

/* verilog/stage_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_tracker import defines::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  instr_t     instr_f,
	input  stage_ctl_t stall,
	input  stage_ctl_t flush,
	output instr_t     instr_d,
	output instr_t     instr_x,
	output instr_t     instr_m,
	output instr_t     instr_w,
	output logic       instr_valid_d,
	output logic       ex_rd_write,
	output logic       mem_rd_write,
	output logic       wb_rd_write
);

	typedef struct packed {
		logic   valid;
		instr_t instr;
	} slot_t;

	localparam slot_t EMPTY_SLOT = '{valid: 1'b0, instr: NOP_INSTR};

	slot_t slot_f;
	slot_t slot_d, slot_x, slot_m, slot_w;
	slot_t next_d, next_x, next_m, next_w;

	// hold wins over bubble, bubble wins over the upstream record
	function automatic slot_t advance(
		input slot_t cur,
		input slot_t prev,
		input logic  hold,
		input logic  drop
	);
		if (hold) begin
			return cur;
		end else if (drop) begin
			return EMPTY_SLOT;
		end
		return prev;
	endfunction

	always_comb begin : fetch_slot
		slot_f.valid = (instr_f.opcode != NOP);
		slot_f.instr = instr_f;
	end

	always_comb begin : next_slots
		// flush_pc squashes whatever is being fetched this cycle
		next_d = advance(slot_d, slot_f, stall.if_id, stall.pc || flush.if_id || flush.pc);
		next_x = advance(slot_x, slot_d, stall.id_ex, stall.if_id || flush.id_ex);
		next_m = advance(slot_m, slot_x, stall.ex_mem, stall.id_ex || flush.ex_mem);
		next_w = advance(slot_w, slot_m, stall.mem_wb, stall.ex_mem || flush.mem_wb);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			slot_d <= EMPTY_SLOT;
			slot_x <= EMPTY_SLOT;
			slot_m <= EMPTY_SLOT;
			slot_w <= EMPTY_SLOT;
		end else begin
			slot_d <= next_d;
			slot_x <= next_x;
			slot_m <= next_m;
			slot_w <= next_w;
		end
	end

	assign instr_d       = slot_d.instr;
	assign instr_x       = slot_x.instr;
	assign instr_m       = slot_m.instr;
	assign instr_w       = slot_w.instr;
	assign instr_valid_d = slot_d.valid;

	// only live records may claim a write back
	assign ex_rd_write  = slot_x.valid && slot_x.instr.rd_write;
	assign mem_rd_write = slot_m.valid && slot_m.instr.rd_write;
	assign wb_rd_write  = slot_w.valid && slot_w.instr.rd_write;

	// stalled registers must keep their contents over the edge
	a_hold_d: assert property (@(posedge clk) disable iff (!arst_n)
		stall.if_id |=> (slot_d == $past(slot_d)))
		else $error("if_id changed while stalled");
	a_hold_x: assert property (@(posedge clk) disable iff (!arst_n)
		stall.id_ex |=> (slot_x == $past(slot_x)))
		else $error("id_ex changed while stalled");
	a_hold_m: assert property (@(posedge clk) disable iff (!arst_n)
		stall.ex_mem |=> (slot_m == $past(slot_m)))
		else $error("ex_mem changed while stalled");
	a_hold_w: assert property (@(posedge clk) disable iff (!arst_n)
		stall.mem_wb |=> (slot_w == $past(slot_w)))
		else $error("mem_wb changed while stalled");

	// holding w while m moves on would drop an instruction
	a_wb_stall_order: assert property (@(posedge clk) disable iff (!arst_n)
		stall.mem_wb |-> stall.ex_mem)
		else $error("mem_wb stalled without ex_mem");

	a_valid_not_nop: assert property (@(posedge clk) disable iff (!arst_n)
		!((slot_d.valid && slot_d.instr.opcode == NOP) ||
		  (slot_x.valid && slot_x.instr.opcode == NOP) ||
		  (slot_m.valid && slot_m.instr.opcode == NOP) ||
		  (slot_w.valid && slot_w.instr.opcode == NOP)))
		else $error("valid bit set on a bubble");

endmodule : stage_tracker

`default_nettype wire
